/* arcade_shell.f */
+incdir+logic
logic/ctrl_pkg.sv
logic/av_pkg.sv
logic/key_decoder.sv
logic/ctrl_mapper.sv
logic/video_out.sv
logic/sd_dac.sv
logic/arcade_shell.sv
test/arcade_checker.sv
test/arcade_shell_tb.sv

/* logic/arcade_cfg.svh */
/*
 * Arcade shell build configuration
 * Pixel clock-enable ratio, audio DAC input width and the
 * line parity value that a frame starts from
 */
`ifndef ARCADE_CFG_SVH
`define ARCADE_CFG_SVH

// ====================
// Pixel timing
// ====================

`define CE_DIV 4            // System clocks per pixel

// ====================
// Audio and video
// ====================

`define DAC_BITS 16         // Sigma-delta input width

// Line parity after reset and while vsync is high
`define SCAN_LINE_RST 1'b0

`endif

/* logic/arcade_shell.sv */
/*
 * Arcade board shell
 * Sits between host I/O and the game core: PS/2 and joystick
 * decoding into the core input ports, the pixel clock enable,
 * VGA output with scanlines and the sigma-delta audio pins
 */
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module arcade_shell
	import av_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	input  logic [7:0]  joystick_0,
	input  logic [7:0]  joystick_1,
	input  logic        rotate,
	input  scan_level_e scanlines,
	input  core_rg_t    core_r,
	input  core_rg_t    core_g,
	input  core_b_t     core_b,
	input  logic        core_hs,
	input  logic        core_vs,
	input  logic        core_hb,
	input  logic        core_vb,
	input  logic [7:0]  core_audio,
	output logic        ce_pix,
	output logic [7:0]  in0,
	output logic [7:0]  in1,
	output vga_chan_t   vga_r,
	output vga_chan_t   vga_g,
	output vga_chan_t   vga_b,
	output logic        vga_hs,
	output logic        vga_vs,
	output logic        audio_l,
	output logic        audio_r
);

	localparam int unsigned       CNT_W   = $clog2(`CE_DIV);
	localparam logic [CNT_W-1:0]  CNT_MAX = CNT_W'(`CE_DIV - 1);

	logic [CNT_W-1:0]     ce_cnt;
	logic                 key_up, key_down, key_left, key_right;
	logic                 key_coin, key_p1, key_p2, key_fire1, key_fire2;
	logic [`DAC_BITS-1:0] dac_sample;

	// ====================
	// Pixel clock enable
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ce_cnt <= '0;
			ce_pix <= 1'b0;
		end else begin
			ce_cnt <= (ce_cnt == CNT_MAX) ? '0 : ce_cnt + 1'b1;
			ce_pix <= (ce_cnt == CNT_MAX);  // One clock in CE_DIV
		end
	end

	// ====================
	// Controls
	// ====================
	key_decoder key_decoder_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ps2_key   (ps2_key),
		.key_up    (key_up),
		.key_down  (key_down),
		.key_left  (key_left),
		.key_right (key_right),
		.key_coin  (key_coin),
		.key_p1    (key_p1),
		.key_p2    (key_p2),
		.key_fire1 (key_fire1),
		.key_fire2 (key_fire2)
	);

	ctrl_mapper ctrl_mapper_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.key_up     (key_up),
		.key_down   (key_down),
		.key_left   (key_left),
		.key_right  (key_right),
		.key_coin   (key_coin),
		.key_p1     (key_p1),
		.key_p2     (key_p2),
		.key_fire1  (key_fire1),
		.key_fire2  (key_fire2),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.in0        (in0),
		.in1        (in1)
	);

	// ====================
	// Video and audio
	// ====================
	video_out video_out_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ce_pix    (ce_pix),
		.core_r    (core_r),
		.core_g    (core_g),
		.core_b    (core_b),
		.core_hs   (core_hs),
		.core_vs   (core_vs),
		.core_hb   (core_hb),
		.core_vb   (core_vb),
		.scanlines (scanlines),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	assign dac_sample = {core_audio, core_audio};   // Full-scale 8 to 16 bits

	sd_dac sd_dac_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.dac_in  (dac_sample),
		.dac_out (audio_l)
	);

	assign audio_r = audio_l;       // Mono core

endmodule

/* logic/av_pkg.sv */
/*
 * Audio/video definitions for the arcade shell
 * Game core colour widths, VGA channel width and
 * the scanline dimming levels
 */
package av_pkg;

	// Core colour, 3-3-2
	typedef logic [2:0] core_rg_t;
	typedef logic [1:0] core_b_t;

	// One VGA DAC channel
	typedef logic [5:0] vga_chan_t;

	// Scanline dimming strength on odd lines
	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		SCAN_25  = 2'd1,
		SCAN_50  = 2'd2,
		SCAN_75  = 2'd3
	} scan_level_e;

endpackage

/* logic/ctrl_mapper.sv */
/*
 * Control mapper
 * Merges keyboard buttons with both joysticks, swaps the
 * directions for a rotated screen and registers the two
 * active-low input-port bytes of the game core
 */
`timescale 1ns/1ps

module ctrl_mapper
	import ctrl_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       key_up,
	input  logic       key_down,
	input  logic       key_left,
	input  logic       key_right,
	input  logic       key_coin,
	input  logic       key_p1,
	input  logic       key_p2,
	input  logic       key_fire1,
	input  logic       key_fire2,     // Bomb has no bit in either port
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic       rotate,
	output logic [7:0] in0,
	output logic [7:0] in1
);

	logic       src_up, src_down, src_left, src_right;
	logic       m_up, m_down, m_left, m_right, m_fire;
	logic [7:0] port0, port1;     // Active high before inversion

	// Each direction from all three sources
	assign src_up    = key_up    | joystick_0[JOY_UP]    | joystick_1[JOY_UP];
	assign src_down  = key_down  | joystick_0[JOY_DOWN]  | joystick_1[JOY_DOWN];
	assign src_left  = key_left  | joystick_0[JOY_LEFT]  | joystick_1[JOY_LEFT];
	assign src_right = key_right | joystick_0[JOY_RIGHT] | joystick_1[JOY_RIGHT];

	// Rotated screen turns the stick a quarter
	assign m_up    = rotate ? src_left  : src_up;
	assign m_down  = rotate ? src_right : src_down;
	assign m_left  = rotate ? src_down  : src_left;
	assign m_right = rotate ? src_up    : src_right;
	assign m_fire  = key_fire1 | joystick_0[JOY_FIRE] | joystick_1[JOY_FIRE];

	always_comb begin
		port0            = '0;
		port0[IN0_UP]    = m_up;
		port0[IN0_LEFT]  = m_left;
		port0[IN0_RIGHT] = m_right;
		port0[IN0_DOWN]  = m_down;
		port0[IN0_COIN]  = key_coin;
		port1            = '0;
		port1[IN1_FIRE]  = m_fire;
		port1[IN1_P1]    = key_p1;
		port1[IN1_P2]    = key_p2;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			in0 <= 8'hFF;               // Nothing pressed
			in1 <= 8'hFF;
		end else begin
			in0 <= ~port0;
			in1 <= ~port1;
		end
	end

endmodule

/* logic/ctrl_pkg.sv */
/*
 * Input-side definitions for the arcade shell
 * PS/2 set 2 key codes, joystick bit positions and
 * bit positions inside the two game input-port bytes
 */
package ctrl_pkg;

	// PS/2 make codes of the keys the shell listens to
	typedef enum logic [7:0] {
		KEY_UP    = 8'h75,
		KEY_DOWN  = 8'h72,
		KEY_LEFT  = 8'h6B,
		KEY_RIGHT = 8'h74,
		KEY_COIN  = 8'h76,  // ESC
		KEY_P1    = 8'h05,  // F1
		KEY_P2    = 8'h06,  // F2
		KEY_FIRE1 = 8'h29,  // Space
		KEY_FIRE2 = 8'h11   // Alt
	} key_code_t;

	// Host joystick word layout
	typedef enum logic [2:0] {
		JOY_RIGHT = 3'd0,
		JOY_LEFT  = 3'd1,
		JOY_DOWN  = 3'd2,
		JOY_UP    = 3'd3,
		JOY_FIRE  = 3'd4,
		JOY_BOMB  = 3'd5
	} joy_bit_e;

	// Input port 0, directions and coin
	typedef enum logic [2:0] {
		IN0_UP    = 3'd0,
		IN0_LEFT  = 3'd1,
		IN0_RIGHT = 3'd2,
		IN0_DOWN  = 3'd3,
		IN0_COIN  = 3'd5
	} in0_bit_e;

	// Input port 1, fire and start buttons
	typedef enum logic [2:0] {
		IN1_FIRE = 3'd3,
		IN1_P1   = 3'd5,
		IN1_P2   = 3'd6
	} in1_bit_e;

endpackage

/* logic/key_decoder.sv */
/*
 * PS/2 key event decoder
 * Detects a new event from the toggle bit and keeps one
 * held level per game button, set on press, cleared on release
 */
`timescale 1ns/1ps

module key_decoder
	import ctrl_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	output logic        key_up,
	output logic        key_down,
	output logic        key_left,
	output logic        key_right,
	output logic        key_coin,
	output logic        key_p1,
	output logic        key_p2,
	output logic        key_fire1,
	output logic        key_fire2
);

	logic      prev_tog;        // Toggle bit seen one edge earlier
	logic      new_event;
	logic      pressed;
	key_code_t code;

	assign new_event = ps2_key[10] ^ prev_tog;
	assign pressed   = ps2_key[9];
	assign code      = key_code_t'(ps2_key[7:0]);

	always_ff @(posedge clk_sys) begin
		prev_tog <= ps2_key[10];
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			key_up    <= 1'b0;
			key_down  <= 1'b0;
			key_left  <= 1'b0;
			key_right <= 1'b0;
			key_coin  <= 1'b0;
			key_p1    <= 1'b0;
			key_p2    <= 1'b0;
			key_fire1 <= 1'b0;
			key_fire2 <= 1'b0;
		end else if (new_event) begin
			case (code)
				KEY_UP:    key_up    <= pressed;
				KEY_DOWN:  key_down  <= pressed;
				KEY_LEFT:  key_left  <= pressed;
				KEY_RIGHT: key_right <= pressed;
				KEY_COIN:  key_coin  <= pressed;
				KEY_P1:    key_p1    <= pressed;
				KEY_P2:    key_p2    <= pressed;
				KEY_FIRE1: key_fire1 <= pressed;
				KEY_FIRE2: key_fire2 <= pressed;
				default: ;                      // Other keys ignored
			endcase
		end
	end

endmodule

/* logic/sd_dac.sv */
/*
 * First-order sigma-delta DAC
 * Adds the sample into an accumulator one bit wider than
 * the input; the carry is the one-bit output stream
 */
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module sd_dac (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic [`DAC_BITS-1:0] dac_in,
	output logic                 dac_out
);

	logic [`DAC_BITS:0] acc;        // Top bit is the carry

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[`DAC_BITS-1:0]} + {1'b0, dac_in};  // Drop last carry
	end

	// Ones density follows dac_in / 2^DAC_BITS
	assign dac_out = acc[`DAC_BITS];

endmodule

/* logic/video_out.sv */
/*
 * Video output stage
 * Blanks the core colour, expands it to 6 bits per channel,
 * dims odd lines by the scanline level and delays the sync
 * through the same pixel-rate register
 */
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module video_out
	import av_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        ce_pix,
	input  core_rg_t    core_r,
	input  core_rg_t    core_g,
	input  core_b_t     core_b,
	input  logic        core_hs,
	input  logic        core_vs,
	input  logic        core_hb,
	input  logic        core_vb,
	input  scan_level_e scanlines,
	output vga_chan_t   vga_r,
	output vga_chan_t   vga_g,
	output vga_chan_t   vga_b,
	output logic        vga_hs,
	output logic        vga_vs
);

	logic      blank;
	logic      hs_rise;
	logic      odd_line;
	logic [2:0] b_wide;
	vga_chan_t exp_r, exp_g, exp_b;

	function automatic vga_chan_t dim(input vga_chan_t c, input scan_level_e lvl);
		case (lvl)
			SCAN_25: dim = c - (c >> 2);    // Three quarters
			SCAN_50: dim = c >> 1;
			SCAN_75: dim = c >> 2;          // One quarter left
			default: dim = c;
		endcase
	endfunction

	// ====================
	// Blank and expand
	// ====================
	assign blank  = core_hb | core_vb;
	assign b_wide = {core_b, core_b[1]};
	assign exp_r  = blank ? '0 : {core_r, core_r};
	assign exp_g  = blank ? '0 : {core_g, core_g};
	assign exp_b  = blank ? '0 : {b_wide, b_wide};

	// vga_hs holds hs from the previous pixel
	assign hs_rise = core_hs & ~vga_hs;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
			odd_line <= `SCAN_LINE_RST;
		end else if (ce_pix) begin
			vga_r  <= odd_line ? dim(exp_r, scanlines) : exp_r;
			vga_g  <= odd_line ? dim(exp_g, scanlines) : exp_g;
			vga_b  <= odd_line ? dim(exp_b, scanlines) : exp_b;
			vga_hs <= core_hs;
			vga_vs <= core_vs;
			if (core_vs)
				odd_line <= `SCAN_LINE_RST;  // Every frame starts on the same parity
			else if (hs_rise)
				odd_line <= ~odd_line;
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the arcade shell testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module arcade_shell_tb \
	-f arcade_shell.f -o arcade_shell_sim
./obj_dir/arcade_shell_sim > sim.log
cat sim.log

# The log decides the result
if grep -q "All tests passed" sim.log; then
	exit 0
fi
exit 1

/* test/arcade_checker.sv */
/*
 * Arcade shell checker
 * Keeps a model of the shell outputs built from the port rules,
 * compares the DUT against it on every clock and counts errors
 */
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module arcade_checker
	import ctrl_pkg::*, av_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	input  logic [7:0]  joystick_0,
	input  logic [7:0]  joystick_1,
	input  logic        rotate,
	input  scan_level_e scanlines,
	input  core_rg_t    core_r,
	input  core_rg_t    core_g,
	input  core_b_t     core_b,
	input  logic        core_hs,
	input  logic        core_vs,
	input  logic        core_hb,
	input  logic        core_vb,
	input  logic [7:0]  core_audio,
	input  logic        ce_pix,
	input  logic [7:0]  in0,
	input  logic [7:0]  in1,
	input  vga_chan_t   vga_r,
	input  vga_chan_t   vga_g,
	input  vga_chan_t   vga_b,
	input  logic        vga_hs,
	input  logic        vga_vs,
	input  logic        audio_l,
	input  logic        audio_r,
	output int          errors,
	output int          checks
);

	int         err_cnt = 0;
	int         chk_cnt = 0;
	logic [8:0] keys;           // up down left right coin p1 p2 fire1 fire2
	logic [3:0] slot;
	logic       tog_last;
	logic       exp_ce, odd, blank;
	logic [7:0] exp_in0, exp_in1;
	vga_chan_t  exp_r, exp_g, exp_b;
	logic       exp_hs, exp_vs;
	longint     n_clk, ones, ones_r, exp_ones;

	assign errors = err_cnt;
	assign checks = chk_cnt;

	// ====================
	// Reference functions
	// ====================

	// Button slot of a key code or 15 for an ignored key
	function automatic logic [3:0] key_slot(input logic [7:0] code);
		case (code)
			KEY_UP:    return 4'd0;
			KEY_DOWN:  return 4'd1;
			KEY_LEFT:  return 4'd2;
			KEY_RIGHT: return 4'd3;
			KEY_COIN:  return 4'd4;
			KEY_P1:    return 4'd5;
			KEY_P2:    return 4'd6;
			KEY_FIRE1: return 4'd7;
			KEY_FIRE2: return 4'd8;
			default:   return 4'd15;
		endcase
	endfunction

	function automatic logic [7:0] port0_ref(input logic [8:0] k, input logic [7:0] j0,
			input logic [7:0] j1, input logic rot);
		logic       u, d, l, r;
		logic [7:0] p;
		u = k[0] | j0[JOY_UP] | j1[JOY_UP];
		d = k[1] | j0[JOY_DOWN] | j1[JOY_DOWN];
		l = k[2] | j0[JOY_LEFT] | j1[JOY_LEFT];
		r = k[3] | j0[JOY_RIGHT] | j1[JOY_RIGHT];
		p = 8'hFF;                          // Unused bits stay high
		p[IN0_UP]    = ~(rot ? l : u);
		p[IN0_LEFT]  = ~(rot ? d : l);
		p[IN0_RIGHT] = ~(rot ? u : r);
		p[IN0_DOWN]  = ~(rot ? r : d);
		p[IN0_COIN]  = ~k[4];
		return p;
	endfunction

	function automatic logic [7:0] port1_ref(input logic [8:0] k, input logic [7:0] j0,
			input logic [7:0] j1);
		logic [7:0] p;
		p = 8'hFF;
		p[IN1_FIRE] = ~(k[7] | j0[JOY_FIRE] | j1[JOY_FIRE]);
		p[IN1_P1]   = ~k[5];
		p[IN1_P2]   = ~k[6];
		return p;
	endfunction

	// Three bits repeated twice is the value times 9
	function automatic vga_chan_t pix_ref(input logic [2:0] v3, input logic blk,
			input logic odd_ln, input scan_level_e lvl);
		int c;
		c = blk ? 0 : int'(v3) * 9;
		if (odd_ln) begin
			case (lvl)
				SCAN_25: c = c - c / 4;
				SCAN_50: c = c / 2;
				SCAN_75: c = c / 4;
				default: ;
			endcase
		end
		return 6'(c);
	endfunction

	task automatic check_value(input string what, input int got, input int exp);
		chk_cnt++;
		if (got != exp) begin
			err_cnt++;
			$display("FAIL %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// ====================
	// Compare and advance
	// ====================
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			keys    = '0;
			exp_in0 = 8'hFF;
			exp_in1 = 8'hFF;
			exp_r   = '0;
			exp_g   = '0;
			exp_b   = '0;
			exp_hs  = 1'b0;
			exp_vs  = 1'b0;
			odd     = 1'b0;
			n_clk   = 0;
			ones    = 0;
			ones_r  = 0;
		end else begin
			// Outputs seen here were set by the previous edge
			exp_ce   = (n_clk != 0) && (n_clk % `CE_DIV == 0);
			ones     = ones + longint'(audio_l);
			ones_r   = ones_r + longint'(audio_r);
			exp_ones = (n_clk * longint'({core_audio, core_audio})) >> `DAC_BITS;
			check_value("ce_pix", int'(ce_pix), int'(exp_ce));
			check_value("in0", int'(in0), int'(exp_in0));
			check_value("in1", int'(in1), int'(exp_in1));
			check_value("vga_r", int'(vga_r), int'(exp_r));
			check_value("vga_g", int'(vga_g), int'(exp_g));
			check_value("vga_b", int'(vga_b), int'(exp_b));
			check_value("vga_hs", int'(vga_hs), int'(exp_hs));
			check_value("vga_vs", int'(vga_vs), int'(exp_vs));
			check_value("audio_l ones", int'(ones), int'(exp_ones));
			check_value("audio_r ones", int'(ones_r), int'(exp_ones));

			exp_in0 = port0_ref(keys, joystick_0, joystick_1, rotate);  // Old keys
			exp_in1 = port1_ref(keys, joystick_0, joystick_1);
			slot    = key_slot(ps2_key[7:0]);
			if (ps2_key[10] != tog_last && slot != 4'd15)
				keys[slot] = ps2_key[9];

			if (exp_ce) begin
				blank = core_hb | core_vb;
				exp_r = pix_ref(core_r, blank, odd, scanlines);
				exp_g = pix_ref(core_g, blank, odd, scanlines);
				exp_b = pix_ref({core_b, core_b[1]}, blank, odd, scanlines);
				if (core_vs)
					odd = 1'b0;
				else if (core_hs && !exp_hs)
					odd = ~odd;             // New line
				exp_hs = core_hs;
				exp_vs = core_vs;
			end
			n_clk++;
		end
		tog_last = ps2_key[10];
	end

endmodule

/* test/arcade_shell_tb.sv */
/*
 * Arcade shell testbench
 * Random key events, joysticks, core video and a held audio
 * byte; the checker module compares every clock
 */
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module arcade_shell_tb
	import ctrl_pkg::*, av_pkg::*;
();

	logic        clk_sys, rst_n;
	logic [10:0] ps2_key;
	logic [7:0]  joystick_0, joystick_1, core_audio;
	logic        rotate;
	scan_level_e scanlines;
	core_rg_t    core_r, core_g;
	core_b_t     core_b;
	logic        core_hs, core_vs, core_hb, core_vb;
	logic        ce_pix, vga_hs, vga_vs, audio_l, audio_r;
	logic [7:0]  in0, in1;
	vga_chan_t   vga_r, vga_g, vga_b;
	logic [7:0]  code;
	logic [3:0]  pick;
	logic [31:0] lfsr_state = 32'h68ae;
	int          err_cnt, chk_cnt;
	int          timeouts = 0;
	logic [7:0]  key_codes [9] = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_COIN,
		KEY_P1, KEY_P2, KEY_FIRE1, KEY_FIRE2};

	arcade_shell dut_i (.*);

	arcade_checker checker_i (.*, .errors(err_cnt), .checks(chk_cnt));

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);     // One step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic apply_reset(input logic [7:0] audio);
		rst_n      = 1'b0;
		core_audio = audio;                     // Audio only changes in reset
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	endtask

	// Bounded wait for the falling edge before a pixel clock
	task automatic wait_ce();
		int i;
		for (i = 0; i < 4 * `CE_DIV; i++) begin
			@(negedge clk_sys);
			if (ce_pix)
				break;
		end
		if (i == 4 * `CE_DIV) begin
			timeouts++;
			$display("Timed out waiting for ce_pix at %0t ns", $time);
		end
	endtask

	initial begin
		ps2_key    = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		rotate     = 1'b0;
		scanlines  = SCAN_OFF;
		{core_r, core_g, core_b} = '0;
		{core_hs, core_vs, core_hb, core_vb} = '0;
		apply_reset(8'(rand_bits(8)));
		repeat (3) @(negedge clk_sys);

		// ====================
		// Key events
		// ====================
		for (int n = 0; n < 300; n++) begin
			pick = 4'(rand_bits(4));
			code = (pick < 4'd9) ? key_codes[pick] : 8'(rand_bits(8));
			ps2_key = {~ps2_key[10], rand_bits(1) == 1, 1'b0, code};
			repeat (1 + int'(rand_bits(2))) @(negedge clk_sys);
		end

		// Joysticks, straight then rotated
		for (int rot = 0; rot < 2; rot++) begin
			rotate = 1'(rot);
			for (int n = 0; n < 100; n++) begin
				joystick_0 = 8'(rand_bits(8));
				joystick_1 = 8'(rand_bits(8));
				@(negedge clk_sys);
			end
		end

		// ====================
		// Video, each scanline level
		// ====================
		for (int lvl = 0; lvl < 4; lvl++) begin
			scanlines = scan_level_e'(lvl);
			for (int px = 0; px < 300; px++) begin
				wait_ce();
				core_r  = 3'(rand_bits(3));
				core_g  = 3'(rand_bits(3));
				core_b  = 2'(rand_bits(2));
				core_hs = (px % 8) < 2;         // Short lines
				core_vs = (px % 96) < 3;
				core_hb = rand_bits(3) == 0;
				core_vb = rand_bits(4) == 0;
			end
		end

		// Audio ones count from a fresh reset
		apply_reset(8'(rand_bits(8)));
		repeat (1024) @(negedge clk_sys);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", chk_cnt, err_cnt, timeouts);
		if (err_cnt == 0 && timeouts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
